/* rtl/dma_aligner.sv */
`timescale 1ns/10ps

module dma_aligner (
    input  logic                           CLK,
    input  logic                           RSTN,
    input  logic                           begin_copy,
    input  logic [dma_pkg::DATA_WIDTH-1:0] src_addr,
    input  logic [dma_pkg::DATA_WIDTH-1:0] dst_addr,
    input  logic [dma_pkg::SIZE_WIDTH-1:0] size,
    input  logic                           rd_valid,
    input  logic [dma_pkg::DATA_WIDTH-1:0] rd_data,
    output logic                           push,
    output dma_pkg::beat_t                 push_beat,
    output logic                           align_done
);

    logic [1:0]                         skip;       // bytes to drop from the next word
    logic [1:0]                         lane;       // next free destination lane
    logic [dma_pkg::SIZE_WIDTH-1:0]     remain;
    logic [dma_pkg::DATA_WIDTH-1:0]     carry_data;
    logic [dma_pkg::STRB_WIDTH-1:0]     carry_strb;
    logic                               flush;
    logic [2:0]                         avail;
    logic [2:0]                         n;
    logic [2:0]                         lane_sum;
    logic                               last;
    logic [2*dma_pkg::DATA_WIDTH-1:0]   win_data;
    logic [2*dma_pkg::STRB_WIDTH-1:0]   win_strb;

    assign avail    = 3'd4 - skip;
    assign n        = (remain < avail) ? remain[2:0] : avail;   // bytes taken this word
    assign lane_sum = {1'b0, lane} + n;
    assign last     = remain == {3'b000, n};

    ////////////////////////////////////////////////////////////////////////////
    // two-word window, carry below and new bytes placed after it
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        win_data = {{dma_pkg::DATA_WIDTH{1'b0}}, carry_data};
        win_strb = {{dma_pkg::STRB_WIDTH{1'b0}}, carry_strb};
        for (int j = 0; j < dma_pkg::STRB_WIDTH; j++) begin
            if (j < n) begin
                win_data[(lane + j) * 8 +: 8] = rd_data[(skip + j) * 8 +: 8];
                win_strb[lane + j] = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            skip       <= '0;
            lane       <= '0;
            remain     <= '0;
            carry_strb <= '0;
            flush      <= 1'b0;
            push       <= 1'b0;
            align_done <= 1'b0;
        end else begin
            push       <= 1'b0;
            align_done <= 1'b0;
            if (begin_copy) begin
                skip       <= src_addr[1:0];
                lane       <= dst_addr[1:0];
                remain     <= size;
                carry_strb <= '0;
            end else if (flush) begin
                push       <= 1'b1;     // leftover bytes of the last word
                align_done <= 1'b1;
                flush      <= 1'b0;
                carry_strb <= '0;
            end else if (rd_valid) begin
                skip   <= '0;
                lane   <= lane_sum[1:0];
                remain <= remain - n;
                push   <= lane_sum[2] | last;
                if (lane_sum[2]) begin
                    carry_strb <= win_strb[2*dma_pkg::STRB_WIDTH-1:dma_pkg::STRB_WIDTH];
                    flush      <= last && win_strb[2*dma_pkg::STRB_WIDTH-1:4] != '0;
                    align_done <= last && win_strb[2*dma_pkg::STRB_WIDTH-1:4] == '0;
                end else begin
                    carry_strb <= last ? '0 : win_strb[dma_pkg::STRB_WIDTH-1:0];
                    align_done <= last;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (flush) begin
            push_beat.data <= carry_data;
            push_beat.strb <= carry_strb;
        end else if (rd_valid) begin
            push_beat.data <= win_data[dma_pkg::DATA_WIDTH-1:0];
            push_beat.strb <= win_strb[dma_pkg::STRB_WIDTH-1:0];
            carry_data     <= lane_sum[2] ? win_data[2*dma_pkg::DATA_WIDTH-1:32]
                                          : win_data[dma_pkg::DATA_WIDTH-1:0];
        end
    end

endmodule

/* rtl/dma_bank_mux.sv */
`timescale 1ns/10ps

module dma_bank_mux (
    input  logic                               CLK,
    input  logic                               RSTN,
    input  logic                               rd_en,
    input  logic [dma_pkg::MEM_ADDR_WIDTH-1:0] rd_addr,
    input  logic                               rd_bank,
    input  logic                               wr_en,
    input  logic [dma_pkg::STRB_WIDTH-1:0]     wr_strb,
    input  logic [dma_pkg::MEM_ADDR_WIDTH-1:0] wr_addr,
    input  logic [dma_pkg::DATA_WIDTH-1:0]     wr_data,
    input  logic                               wr_bank,
    output logic                               mem0_en,
    output logic [dma_pkg::STRB_WIDTH-1:0]     mem0_we,
    output logic [dma_pkg::MEM_ADDR_WIDTH-1:0] mem0_addr,
    output logic [dma_pkg::DATA_WIDTH-1:0]     mem0_wdata,
    input  logic [dma_pkg::DATA_WIDTH-1:0]     mem0_rdata,
    output logic                               mem1_en,
    output logic [dma_pkg::STRB_WIDTH-1:0]     mem1_we,
    output logic [dma_pkg::MEM_ADDR_WIDTH-1:0] mem1_addr,
    output logic [dma_pkg::DATA_WIDTH-1:0]     mem1_wdata,
    input  logic [dma_pkg::DATA_WIDTH-1:0]     mem1_rdata,
    output logic                               rd_valid,
    output logic [dma_pkg::DATA_WIDTH-1:0]     rd_data
);

    logic rd_sel;   // bank of the read in flight

    always_comb begin
        mem0_en    = 1'b0;
        mem1_en    = 1'b0;
        mem0_we    = '0;
        mem1_we    = '0;
        mem0_addr  = wr_en ? wr_addr : rd_addr;
        mem1_addr  = wr_en ? wr_addr : rd_addr;
        mem0_wdata = wr_data;
        mem1_wdata = wr_data;
        if (wr_en) begin
            mem0_en = wr_bank;
            mem1_en = ~wr_bank;
            mem0_we = wr_bank ? wr_strb : '0;
            mem1_we = wr_bank ? '0 : wr_strb;
        end else if (rd_en) begin
            mem0_en = rd_bank;
            mem1_en = ~rd_bank;
        end
    end

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            rd_valid <= 1'b0;
            rd_sel   <= 1'b0;
        end else begin
            rd_valid <= rd_en & ~wr_en;
            rd_sel   <= rd_bank;
        end
    end

    assign rd_data = rd_sel ? mem0_rdata : mem1_rdata;

endmodule

/* rtl/dma_ctrl.sv */
`timescale 1ns/10ps

module dma_ctrl (
    input  logic                               CLK,
    input  logic                               RSTN,
    input  logic                               start,
    input  logic [dma_pkg::DATA_WIDTH-1:0]     src_addr,
    input  logic [dma_pkg::SIZE_WIDTH-1:0]     size,
    output logic                               busy,
    output logic                               rd_en,
    output logic [dma_pkg::MEM_ADDR_WIDTH-1:0] rd_addr,
    output logic                               rd_bank,
    output logic                               begin_copy,
    input  logic                               align_done,
    output logic                               wr_start,
    input  logic                               wr_done,
    output logic                               done
);

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_align_wait,
        st_write,
        st_finish
    } state_t;

    state_t     state;
    logic [6:0] n_words;
    logic [6:0] rd_left;

    // source words touched = ceil((offset + size) / 4)
    assign n_words = (7'(src_addr[1:0]) + 7'(size) + 7'd3) >> 2;

    assign busy       = state != st_idle;
    assign rd_en      = state == st_read;
    assign begin_copy = start && state == st_idle && size != '0;
    assign wr_start   = state == st_align_wait && align_done;
    assign done       = state == st_finish;

    ////////////////////////////////////////////////////////////////////////////
    // phase sequencing
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:       if (start) state <= (size == '0) ? st_finish : st_read;
                st_read:       if (rd_left == 7'd1) state <= st_align_wait;
                st_align_wait: if (align_done) state <= st_write;
                st_write:      if (wr_done) state <= st_finish;
                default:       state <= st_idle;    // finish lasts one cycle
            endcase
        end
    end

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            rd_addr <= '0;
            rd_bank <= 1'b0;
            rd_left <= '0;
        end else if (begin_copy) begin
            rd_addr <= src_addr[2 +: dma_pkg::MEM_ADDR_WIDTH];
            rd_bank <= src_addr[dma_pkg::BANK_BIT];
            rd_left <= n_words;
        end else if (rd_en) begin
            rd_addr <= rd_addr + 1'b1;
            rd_left <= rd_left - 1'b1;
        end
    end

endmodule

/* rtl/dma_fifo.sv */
`timescale 1ns/10ps

module dma_fifo (
    input  logic           CLK,
    input  logic           RSTN,
    input  logic           push,
    input  dma_pkg::beat_t push_beat,
    input  logic           pop,
    output dma_pkg::beat_t pop_beat,
    output logic           empty,
    output logic           full
);

    dma_pkg::beat_t             mem [dma_pkg::FIFO_DEPTH];
    logic [dma_pkg::FIFO_AW:0]  wr_ptr;     // msb is the wrap bit
    logic [dma_pkg::FIFO_AW:0]  rd_ptr;

    assign empty    = wr_ptr == rd_ptr;
    assign full     = wr_ptr == {~rd_ptr[dma_pkg::FIFO_AW], rd_ptr[dma_pkg::FIFO_AW-1:0]};
    assign pop_beat = mem[rd_ptr[dma_pkg::FIFO_AW-1:0]];   // head shown directly

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (push)
            mem[wr_ptr[dma_pkg::FIFO_AW-1:0]] <= push_beat;
    end

endmodule

/* rtl/dma_pkg.sv */
package dma_pkg;

    localparam int MEM_ADDR_WIDTH = 16;
    localparam int DATA_WIDTH     = 32;
    localparam int STRB_WIDTH     = 4;
    localparam int APB_ADDR_WIDTH = 32;
    localparam int SIZE_WIDTH     = 6;
    localparam int BANK_BIT       = 20;     // 1 -> mem0, 0 -> mem1
    localparam int FIFO_DEPTH     = 32;     // 63 bytes never need more than 17 beats
    localparam int FIFO_AW        = $clog2(FIFO_DEPTH);

    // apb register map
    localparam logic [APB_ADDR_WIDTH-1:0] REG_SRC  = 32'h0000_0000;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_DST  = 32'h0000_0004;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_SIZE = 32'h0000_0008;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL = 32'h0000_000C;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_INT  = 32'h0000_0010;

    // one destination word and the lanes it carries
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
    } beat_t;

endpackage

/* rtl/dma_regs.sv */
`timescale 1ns/10ps

module dma_regs (
    input  logic                               CLK,
    input  logic                               RSTN,
    input  logic                               PSEL,
    input  logic                               PENABLE,
    input  logic                               PWRITE,
    input  logic [dma_pkg::APB_ADDR_WIDTH-1:0] PADDR,
    input  logic [dma_pkg::DATA_WIDTH-1:0]     PWDATA,
    output logic                               PREADY,
    output logic [dma_pkg::DATA_WIDTH-1:0]     PRDATA,
    output logic                               INTR,
    input  logic                               busy,
    input  logic                               done,
    output logic                               start,
    output logic [dma_pkg::DATA_WIDTH-1:0]     src_addr,
    output logic [dma_pkg::DATA_WIDTH-1:0]     dst_addr,
    output logic [dma_pkg::SIZE_WIDTH-1:0]     size
);

    logic                           acc;
    logic                           wr_acc;
    logic [dma_pkg::DATA_WIDTH-1:0] rd_val;

    assign acc    = PSEL & PENABLE & ~PREADY;   // second access cycle is not decoded again
    assign wr_acc = acc & PWRITE;

    always_comb begin
        rd_val = '0;
        case (PADDR)
            dma_pkg::REG_SRC:  rd_val = src_addr;
            dma_pkg::REG_DST:  rd_val = dst_addr;
            dma_pkg::REG_SIZE: rd_val[dma_pkg::SIZE_WIDTH-1:0] = size;
            dma_pkg::REG_CTRL: rd_val[0] = busy;
            dma_pkg::REG_INT:  rd_val[0] = INTR;
            default:           rd_val = '0;         // unmapped
        endcase
    end

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            PREADY   <= 1'b0;
            start    <= 1'b0;
            INTR     <= 1'b0;
            src_addr <= '0;
            dst_addr <= '0;
            size     <= '0;
        end else begin
            PREADY <= acc;
            start  <= wr_acc && PADDR == dma_pkg::REG_CTRL && PWDATA[0] && !busy;
            if (wr_acc && PADDR == dma_pkg::REG_SRC)
                src_addr <= PWDATA;
            if (wr_acc && PADDR == dma_pkg::REG_DST)
                dst_addr <= PWDATA;
            if (wr_acc && PADDR == dma_pkg::REG_SIZE)
                size <= PWDATA[dma_pkg::SIZE_WIDTH-1:0];
            if (done)
                INTR <= 1'b1;
            else if (wr_acc && PADDR == dma_pkg::REG_INT && PWDATA[0])
                INTR <= 1'b0;   // write 1 to clear
        end
    end

    always_ff @(posedge CLK) begin
        if (acc && !PWRITE)
            PRDATA <= rd_val;
    end

endmodule

/* rtl/dma_top.sv */
`timescale 1ns/10ps

module dma_top (
    input  logic                               CLK,
    input  logic                               RSTN,
    output logic                               INTR,
    input  logic                               PSEL,
    input  logic                               PENABLE,
    input  logic                               PWRITE,
    input  logic [dma_pkg::APB_ADDR_WIDTH-1:0] PADDR,
    input  logic [dma_pkg::DATA_WIDTH-1:0]     PWDATA,
    output logic                               PREADY,
    output logic [dma_pkg::DATA_WIDTH-1:0]     PRDATA,
    output logic                               mem0_en,
    output logic [dma_pkg::STRB_WIDTH-1:0]     mem0_we,
    output logic [dma_pkg::MEM_ADDR_WIDTH-1:0] mem0_addr,
    output logic [dma_pkg::DATA_WIDTH-1:0]     mem0_wdata,
    input  logic [dma_pkg::DATA_WIDTH-1:0]     mem0_rdata,
    output logic                               mem1_en,
    output logic [dma_pkg::STRB_WIDTH-1:0]     mem1_we,
    output logic [dma_pkg::MEM_ADDR_WIDTH-1:0] mem1_addr,
    output logic [dma_pkg::DATA_WIDTH-1:0]     mem1_wdata,
    input  logic [dma_pkg::DATA_WIDTH-1:0]     mem1_rdata
);

    // register block to sequencer
    logic                               start;
    logic                               busy;
    logic                               done;
    logic [dma_pkg::DATA_WIDTH-1:0]     src_addr;
    logic [dma_pkg::DATA_WIDTH-1:0]     dst_addr;
    logic [dma_pkg::SIZE_WIDTH-1:0]     size;

    // read phase
    logic                               rd_en;
    logic [dma_pkg::MEM_ADDR_WIDTH-1:0] rd_addr;
    logic                               rd_bank;
    logic                               rd_valid;
    logic [dma_pkg::DATA_WIDTH-1:0]     rd_data;
    logic                               begin_copy;
    logic                               align_done;

    // fifo
    logic                               push;
    dma_pkg::beat_t                     push_beat;
    logic                               pop;
    dma_pkg::beat_t                     pop_beat;
    logic                               empty;
    logic                               full;

    // write phase
    logic                               wr_start;
    logic                               wr_done;
    logic                               wr_en;
    logic [dma_pkg::STRB_WIDTH-1:0]     wr_strb;
    logic [dma_pkg::MEM_ADDR_WIDTH-1:0] wr_addr;
    logic [dma_pkg::DATA_WIDTH-1:0]     wr_data;
    logic                               wr_bank;

    ////////////////////////////////////////////////////////////////////////////
    // instances
    ////////////////////////////////////////////////////////////////////////////
    dma_regs regs_i (
        .CLK, .RSTN, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
        .PREADY, .PRDATA, .INTR,
        .busy, .done, .start, .src_addr, .dst_addr, .size
    );

    dma_ctrl ctrl_i (
        .CLK, .RSTN, .start, .src_addr, .size, .busy,
        .rd_en, .rd_addr, .rd_bank, .begin_copy, .align_done,
        .wr_start, .wr_done, .done
    );

    dma_aligner aligner_i (
        .CLK, .RSTN, .begin_copy, .src_addr, .dst_addr, .size,
        .rd_valid, .rd_data, .push, .push_beat, .align_done
    );

    dma_fifo fifo_i (
        .CLK, .RSTN, .push, .push_beat, .pop, .pop_beat, .empty, .full
    );

    dma_writer writer_i (
        .CLK, .RSTN, .wr_start, .dst_addr, .empty, .pop_beat, .pop,
        .wr_en, .wr_strb, .wr_addr, .wr_data, .wr_bank, .wr_done
    );

    dma_bank_mux bank_mux_i (
        .CLK, .RSTN, .rd_en, .rd_addr, .rd_bank,
        .wr_en, .wr_strb, .wr_addr, .wr_data, .wr_bank,
        .mem0_en, .mem0_we, .mem0_addr, .mem0_wdata, .mem0_rdata,
        .mem1_en, .mem1_we, .mem1_addr, .mem1_wdata, .mem1_rdata,
        .rd_valid, .rd_data
    );

endmodule

/* rtl/dma_writer.sv */
`timescale 1ns/10ps

module dma_writer (
    input  logic                               CLK,
    input  logic                               RSTN,
    input  logic                               wr_start,
    input  logic [dma_pkg::DATA_WIDTH-1:0]     dst_addr,
    input  logic                               empty,
    input  dma_pkg::beat_t                     pop_beat,
    output logic                               pop,
    output logic                               wr_en,
    output logic [dma_pkg::STRB_WIDTH-1:0]     wr_strb,
    output logic [dma_pkg::MEM_ADDR_WIDTH-1:0] wr_addr,
    output logic [dma_pkg::DATA_WIDTH-1:0]     wr_data,
    output logic                               wr_bank,
    output logic                               wr_done
);

    logic active;

    assign pop     = active & ~empty;
    assign wr_en   = pop;               // one word per popped beat
    assign wr_strb = pop_beat.strb;
    assign wr_data = pop_beat.data;
    assign wr_done = active & empty;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            active  <= 1'b0;
            wr_addr <= '0;
            wr_bank <= 1'b0;
        end else if (wr_start) begin
            active  <= 1'b1;
            wr_addr <= dst_addr[2 +: dma_pkg::MEM_ADDR_WIDTH];
            wr_bank <= dst_addr[dma_pkg::BANK_BIT];
        end else if (wr_done) begin
            active <= 1'b0;
        end else if (pop) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

endmodule

/* src.f */
rtl/dma_pkg.sv
rtl/dma_regs.sv
rtl/dma_ctrl.sv
rtl/dma_aligner.sv
rtl/dma_fifo.sv
rtl/dma_writer.sv
rtl/dma_bank_mux.sv
rtl/dma_top.sv
testbench/dma_tb_clock.sv
testbench/dma_assertions.sv
testbench/dma_tb.sv

/* testbench/dma_assertions.sv */
`timescale 1ns/10ps

module dma_assertions (
    input logic                           CLK,
    input logic                           RSTN,
    input logic                           PSEL,
    input logic                           PENABLE,
    input logic                           PREADY,
    input logic                           INTR,
    input logic                           push,
    input logic                           full,
    input logic                           mem0_en,
    input logic                           mem1_en,
    input logic [dma_pkg::STRB_WIDTH-1:0] mem0_we,
    input logic [dma_pkg::STRB_WIDTH-1:0] mem1_we
);

    one_bank_at_a_time: assert property (@(posedge CLK) disable iff (!RSTN)
        !(mem0_en && mem1_en))
        else $error("mem0_en and mem1_en high together");

    ready_after_access: assert property (@(posedge CLK) disable iff (!RSTN)
        PREADY |-> $past(PSEL && PENABLE))
        else $error("PREADY without a preceding access cycle");

    no_push_when_full: assert property (@(posedge CLK) disable iff (!RSTN)
        !(push && full))
        else $error("FIFO pushed while full");

    intr_after_writes: assert property (@(posedge CLK) disable iff (!RSTN)
        $rose(INTR) |-> (mem0_we == '0 && mem1_we == '0))
        else $error("INTR rose during a memory write");

endmodule

bind dma_top dma_assertions assertions_i (
    .CLK, .RSTN, .PSEL, .PENABLE, .PREADY, .INTR, .push, .full,
    .mem0_en, .mem1_en, .mem0_we, .mem1_we
);

/* testbench/dma_tb.sv */
`timescale 1ns/10ps

module dma_tb;

    localparam int TIMEOUT_CYCLES = 30000;  // ~40 copies of up to 150 cycles plus apb traffic
    localparam int INTR_LIMIT     = 400;

    logic        CLK;
    logic        RSTN;
    logic        INTR;
    logic        PSEL;
    logic        PENABLE;
    logic        PWRITE;
    logic [31:0] PADDR;
    logic [31:0] PWDATA;
    logic        PREADY;
    logic [31:0] PRDATA;
    logic        mem0_en;
    logic [3:0]  mem0_we;
    logic [15:0] mem0_addr;
    logic [31:0] mem0_wdata;
    logic [31:0] mem0_rdata;
    logic        mem1_en;
    logic [3:0]  mem1_we;
    logic [15:0] mem1_addr;
    logic [31:0] mem1_wdata;
    logic [31:0] mem1_rdata;

    logic [31:0] mem0 [0:65535];
    logic [31:0] mem1 [0:65535];
    logic [31:0] mem0_q = '0;
    logic [31:0] mem1_q = '0;
    logic [31:0] seed = 32'h8a8b_7c14;
    int          checks = 0;
    int          errors = 0;
    int          test_start_errors;
    int          cycles = 0;
    int          intr_rises = 0;
    int          en_count = 0;
    logic        intr_q = 1'b0;

    dma_tb_clock clock_i (.CLK(CLK), .RSTN(RSTN));

    dma_top dut_i (.*);

    ////////////////////////////////////////////////////////////////////////////
    // memory models, one cycle read latency
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge CLK) begin
        if (mem0_en) begin
            for (int b = 0; b < 4; b++)
                if (mem0_we[b])
                    mem0[mem0_addr][8*b +: 8] <= mem0_wdata[8*b +: 8];
            mem0_q <= mem0[mem0_addr];
        end
        if (mem1_en) begin
            for (int b = 0; b < 4; b++)
                if (mem1_we[b])
                    mem1[mem1_addr][8*b +: 8] <= mem1_wdata[8*b +: 8];
            mem1_q <= mem1[mem1_addr];
        end
    end

    // read data reaches the DUT half a cycle later
    always @(negedge CLK) begin
        mem0_rdata <= mem0_q;
        mem1_rdata <= mem1_q;
    end

    // monitors and run limit
    always @(posedge CLK) begin
        intr_q <= INTR;
        if (INTR && !intr_q)
            intr_rises++;
        if (mem0_en || mem1_en)
            en_count++;
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] rand_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // bit 20 set means mem0
    function automatic logic [7:0] mem_byte(input logic [31:0] addr);
        logic [31:0] w;
        w = addr[20] ? mem0[addr[17:2]] : mem1[addr[17:2]];
        return w[8*addr[1:0] +: 8];
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: %s, %0d errors", name, (errors == test_start_errors) ? "ok" : "failed",
                 errors - test_start_errors);
        test_start_errors = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // apb access, called at a falling edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic apb_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = wr;
        PADDR   = addr;
        PWDATA  = wdata;
        @(negedge CLK);
        PENABLE = 1'b1;
        n = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (!PREADY && n < 8);
        checks++;
        if (!PREADY) begin
            errors++;
            $display("PREADY never came for the access at 0x%h", addr);
        end else if (n != 1) begin
            errors++;
            $display("error: PREADY cycles got 0x%h expected 0x%h", n, 1);
        end
        @(negedge CLK);     // second access cycle, completes with PREADY high
        rdata   = PRDATA;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        apb_access(1'b0, addr, 32'h0, data);
    endtask

    task automatic wait_intr(output int n);
        n = 0;
        while (!INTR && n < INTR_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        checks++;
        if (!INTR) begin
            errors++;
            $display("INTR did not rise within %0d cycles", INTR_LIMIT);
        end
    endtask

    // copies and checks the destination plus four bytes on each side
    task automatic run_copy(input logic [31:0] src, input logic [31:0] dst, input int size);
        logic [7:0]  src_bytes [$];
        logic [7:0]  old_bytes [$];
        logic [7:0]  exp;
        logic [7:0]  got;
        logic [31:0] addr;
        int          n;
        for (int i = 0; i < size; i++)
            src_bytes.push_back(mem_byte(src + i));
        for (int i = 0; i < size + 8; i++)
            old_bytes.push_back(mem_byte(dst - 4 + i));
        apb_write(dma_pkg::REG_SRC, src);
        apb_write(dma_pkg::REG_DST, dst);
        apb_write(dma_pkg::REG_SIZE, size);
        apb_write(dma_pkg::REG_CTRL, 32'h1);
        wait_intr(n);
        for (int i = 0; i < size + 8; i++) begin
            addr = dst - 4 + i;
            got  = mem_byte(addr);
            exp  = (i >= 4 && i < size + 4) ? src_bytes[i-4] : old_bytes[i];
            checks++;
            if (got !== exp) begin
                errors++;
                $display("error: %s byte 0x%h got 0x%h expected 0x%h",
                         addr[20] ? "mem0" : "mem1", addr, got, exp);
            end
        end
        apb_write(dma_pkg::REG_INT, 32'h1);
        check_val("INTR", INTR, 0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic test_registers();
        logic [31:0] rd;
        apb_write(dma_pkg::REG_SRC, 32'h0012_3457);
        apb_write(dma_pkg::REG_DST, 32'h0010_89ab);
        apb_write(dma_pkg::REG_SIZE, 32'hffff_ffea);
        apb_write(32'h14, 32'hffff_ffff);
        apb_read(dma_pkg::REG_SRC, rd);
        check_val("PRDATA src", rd, 32'h0012_3457);
        apb_read(dma_pkg::REG_DST, rd);
        check_val("PRDATA dst", rd, 32'h0010_89ab);
        apb_read(dma_pkg::REG_SIZE, rd);
        check_val("PRDATA size", rd, 32'h2a);    // 6 bit field
        apb_read(32'h14, rd);
        check_val("PRDATA unmapped", rd, 32'h0);
        end_test("registers");
    endtask

    task automatic test_misaligned();
        logic [31:0] src;
        logic [31:0] dst;
        logic        to_mem0;
        int          k;
        k = 0;
        for (int so = 0; so < 4; so++) begin
            for (int dof = 0; dof < 4; dof++) begin
                to_mem0 = k[0];
                src = (to_mem0 ? 32'h0 : 32'h0010_0000) | (32'h1000 + k * 32'h100 + so);
                dst = (to_mem0 ? 32'h0010_0000 : 32'h0) | (32'h2000 + k * 32'h100 + dof);
                run_copy(src, dst, (rand_next() % 63) + 1);
                k++;
            end
        end
        end_test("misaligned copies");
    endtask

    task automatic test_interrupt();
        logic [31:0] rd;
        int          n;
        apb_write(dma_pkg::REG_SRC, 32'h0000_4001);
        apb_write(dma_pkg::REG_DST, 32'h0010_4002);
        apb_write(dma_pkg::REG_SIZE, 63);
        intr_rises = 0;
        apb_write(dma_pkg::REG_CTRL, 32'h1);
        apb_read(dma_pkg::REG_CTRL, rd);
        check_val("PRDATA busy", rd, 32'h1);
        apb_write(dma_pkg::REG_CTRL, 32'h1);     // ignored while busy
        wait_intr(n);
        apb_read(dma_pkg::REG_INT, rd);
        check_val("PRDATA int", rd, 32'h1);
        apb_write(dma_pkg::REG_INT, 32'h1);
        check_val("INTR", INTR, 0);
        repeat (60) @(negedge CLK);
        check_val("INTR rises", intr_rises, 1);
        end_test("interrupt and status");
    endtask

    task automatic test_size_zero();
        int n;
        apb_write(dma_pkg::REG_SIZE, 32'h0);
        en_count = 0;
        apb_write(dma_pkg::REG_CTRL, 32'h1);
        wait_intr(n);
        checks++;
        if (n > 3) begin
            errors++;
            $display("INTR took %0d cycles for a zero size copy, more than 3", n);
        end
        check_val("mem enables", en_count, 0);
        apb_write(dma_pkg::REG_INT, 32'h1);
        end_test("size zero");
    endtask

    initial begin
        PSEL       = 1'b0;
        PENABLE    = 1'b0;
        PWRITE     = 1'b0;
        PADDR      = '0;
        PWDATA     = '0;
        mem0_rdata = '0;
        mem1_rdata = '0;
        for (int i = 0; i < 65536; i++) begin
            mem0[i] = rand_next();
            mem1[i] = rand_next();
        end
        test_start_errors = 0;
        @(posedge RSTN);
        @(negedge CLK);
        test_registers();
        run_copy(32'h0000_0100, 32'h0010_0200, 16);
        end_test("aligned copy");
        test_misaligned();
        run_copy(32'h0010_3003, 32'h0010_3102, 50);
        end_test("same bank copy");
        test_interrupt();
        test_size_zero();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* testbench/dma_tb_clock.sv */
`timescale 1ns/10ps

module dma_tb_clock (
    output logic CLK,
    output logic RSTN
);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;     // 100 ns period
    end

    initial begin
        RSTN = 1'b0;
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        RSTN = 1'b1;
    end

endmodule
